//--- cnn_infer_top.f
+incdir+verification
source/cnn_pkg.sv
source/window_scanner.sv
source/conv_channel.sv
source/fc_stage.sv
source/cnn_infer_top.sv
verification/tb_clock_gen.sv
verification/cnn_infer_properties.sv
verification/cnn_infer_tb.sv

//--- source/cnn_infer_top.sv
// Start is taken only while ready is high and up to two images are in flight with results in order
module cnn_infer_top
    import cnn_pkg::*;
#(
    parameter int IN_SIZE     = 4,
    parameter int KERNEL_SIZE = 3,
    parameter int NUM_FILTERS = 4,
    parameter int FC1_NEURONS = 8
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  sample_t image [IN_SIZE][IN_SIZE],
    output logic    ready,
    output sample_t result,
    output logic    done
);

    localparam int OUT_SIZE  = IN_SIZE - KERNEL_SIZE + 1;
    localparam int PATCH_LEN = KERNEL_SIZE * KERNEL_SIZE;
    localparam int MAP_LEN   = OUT_SIZE * OUT_SIZE;
    localparam int FLAT_LEN  = NUM_FILTERS * MAP_LEN;
    localparam int POS_W     = (MAP_LEN > 1) ? $clog2(MAP_LEN) : 1;

    sample_t          patch [PATCH_LEN];
    logic             patch_valid;
    logic [POS_W-1:0] patch_pos;
    logic             maps_valid;
    logic             fc_ready;
    sample_t          maps [NUM_FILTERS][MAP_LEN];
    sample_t          flat [FLAT_LEN];

    window_scanner #(
        .IN_SIZE     (IN_SIZE),
        .KERNEL_SIZE (KERNEL_SIZE)
    ) i_scanner (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .image       (image),
        .fc_ready    (fc_ready),
        .ready       (ready),
        .patch       (patch),
        .patch_valid (patch_valid),
        .patch_pos   (patch_pos),
        .maps_valid  (maps_valid)
    );

    // ----------------------------------------
    // Conv channels and flattening
    // ----------------------------------------
    for (genvar f = 0; f < NUM_FILTERS; f++) begin : g_conv
        conv_channel #(
            .KERNEL_SIZE (KERNEL_SIZE),
            .OUT_SIZE    (OUT_SIZE)
        ) i_channel (
            .clk         (clk),
            .rst         (rst),
            .patch       (patch),
            .patch_valid (patch_valid),
            .patch_pos   (patch_pos),
            .map         (maps[f])
        );

        for (genvar p = 0; p < MAP_LEN; p++) begin : g_flat
            assign flat[f * MAP_LEN + p] = maps[f][p];  // Filter-major
        end
    end

    fc_stage #(
        .FLAT_LEN    (FLAT_LEN),
        .FC1_NEURONS (FC1_NEURONS)
    ) i_fc (
        .clk         (clk),
        .rst         (rst),
        .flat        (flat),
        .maps_valid  (maps_valid),
        .fc_ready    (fc_ready),
        .result      (result),
        .done        (done)
    );

endmodule

//--- source/cnn_pkg.sv
// Q8.8 fixed point with 32-bit sums and truncating rescale, and every weight is a fixed constant
package cnn_pkg;

    // ----------------------------------------
    // Widths and fixed-point format
    // ----------------------------------------
    localparam int DATA_W    = 16;  // Q8.8 sample
    localparam int FRAC_BITS = 8;
    localparam int ACC_W     = 32;  // Full product and running sum

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // ----------------------------------------
    // Network constants
    // ----------------------------------------
    // Same value for every tap of every filter
    localparam sample_t CONV_WEIGHT = 16'sd16;  // 0.0625

    // Shared by all FC1 neurons and all their inputs
    localparam sample_t FC1_WEIGHT = 16'sd8;  // 0.03125
    localparam sample_t FC2_WEIGHT = 16'sd16; // 0.0625

    localparam sample_t FC1_BIAS = 16'sd0;
    localparam sample_t FC2_BIAS = 16'sd0;

    // ----------------------------------------
    // Control FSM states
    // ----------------------------------------
    // Window scanner
    typedef enum logic [1:0] {
        SCAN_IDLE,  // Waiting for a start
        SCAN_RUN,   // One output position per cycle
        SCAN_HOLD   // Maps complete, FC stage still busy
    } scan_state_t;

    // Fully connected stage
    typedef enum logic [1:0] {
        FC_IDLE,
        FC_HIDDEN,  // One FC1 neuron per cycle
        FC_OUTPUT   // Single FC2 neuron
    } fc_state_t;

endpackage

//--- source/conv_channel.sv
// One filter with all taps equal to CONV_WEIGHT and the 32-bit sum wraps without saturation
module conv_channel
    import cnn_pkg::*;
#(
    parameter int KERNEL_SIZE  = 3,
    parameter int OUT_SIZE     = 2,
    localparam int PATCH_LEN   = KERNEL_SIZE * KERNEL_SIZE,
    localparam int MAP_LEN     = OUT_SIZE * OUT_SIZE,
    localparam int POS_W       = (MAP_LEN > 1) ? $clog2(MAP_LEN) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  sample_t          patch [PATCH_LEN],
    input  logic             patch_valid,
    input  logic [POS_W-1:0] patch_pos,
    output sample_t          map [MAP_LEN]
);

    acc_t    prod [PATCH_LEN];
    acc_t    acc;
    acc_t    scaled;
    sample_t conv_val;
    sample_t relu_val;

    // ----------------------------------------
    // Multiply-accumulate and rescale
    // ----------------------------------------
    always_comb begin
        acc = '0;
        for (int i = 0; i < PATCH_LEN; i++) begin
            prod[i] = patch[i] * CONV_WEIGHT;  // Q16.16
            acc     = acc + prod[i];
        end
    end

    assign scaled   = acc >>> FRAC_BITS;
    assign conv_val = sample_t'(scaled);  // Keep low 16 bits

    // ReLU
    assign relu_val = conv_val[DATA_W-1] ? '0 : conv_val;

    // ----------------------------------------
    // Map storage
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int p = 0; p < MAP_LEN; p++) begin
                map[p] <= '0;
            end
        end else if (patch_valid) begin
            map[patch_pos] <= relu_val;
        end
    end

endmodule

//--- source/fc_stage.sv
// FC1 neurons share one weight so each hidden value differs only by its slot, and biases wrap at 16 bits
module fc_stage
    import cnn_pkg::*;
#(
    parameter int FLAT_LEN    = 16,
    parameter int FC1_NEURONS = 8
) (
    input  logic    clk,
    input  logic    rst,
    input  sample_t flat [FLAT_LEN],
    input  logic    maps_valid,
    output logic    fc_ready,
    output sample_t result,
    output logic    done
);

    localparam int IDX_W = (FC1_NEURONS > 1) ? $clog2(FC1_NEURONS) : 1;

    fc_state_t        state;
    logic [IDX_W-1:0] idx;  // Hidden neuron being computed
    logic             capture;
    logic             last_neuron;

    sample_t flat_q [FLAT_LEN];
    sample_t hidden [FC1_NEURONS];

    acc_t    fc1_prod [FLAT_LEN];
    acc_t    fc1_acc;
    acc_t    fc1_scaled;
    sample_t hid_val;

    acc_t    fc2_prod [FC1_NEURONS];
    acc_t    fc2_acc;
    acc_t    fc2_scaled;
    sample_t out_val;

    assign fc_ready    = (state == FC_IDLE);
    assign capture     = fc_ready && maps_valid;
    assign last_neuron = (idx == IDX_W'(FC1_NEURONS - 1));

    // ----------------------------------------
    // FC1 neuron datapath
    // ----------------------------------------
    always_comb begin
        fc1_acc = '0;
        for (int i = 0; i < FLAT_LEN; i++) begin
            fc1_prod[i] = flat_q[i] * FC1_WEIGHT;
            fc1_acc     = fc1_acc + fc1_prod[i];
        end
    end

    assign fc1_scaled = fc1_acc >>> FRAC_BITS;
    assign hid_val    = sample_t'(fc1_scaled) + FC1_BIAS;  // No activation on FC1

    // ----------------------------------------
    // FC2 neuron datapath
    // ----------------------------------------
    always_comb begin
        fc2_acc = '0;
        for (int j = 0; j < FC1_NEURONS; j++) begin
            fc2_prod[j] = hidden[j] * FC2_WEIGHT;
            fc2_acc     = fc2_acc + fc2_prod[j];
        end
    end

    assign fc2_scaled = fc2_acc >>> FRAC_BITS;
    assign out_val    = sample_t'(fc2_scaled) + FC2_BIAS;

    // ----------------------------------------
    // Operand and hidden vector storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (capture) begin
            flat_q <= flat;  // Frees the maps for the next image
        end
        if (state == FC_HIDDEN) begin
            hidden[idx] <= hid_val;
        end
    end

    // ----------------------------------------
    // Sequencing
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= FC_IDLE;
            idx    <= '0;
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;  // Single-cycle pulse
            case (state)
                FC_IDLE: begin
                    if (capture) begin
                        idx   <= '0;
                        state <= FC_HIDDEN;
                    end
                end
                FC_HIDDEN: begin
                    if (last_neuron) begin
                        idx   <= '0;
                        state <= FC_OUTPUT;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                FC_OUTPUT: begin
                    result <= out_val;
                    done   <= 1'b1;
                    state  <= FC_IDLE;
                end
                default: state <= FC_IDLE;
            endcase
        end
    end

endmodule

//--- source/window_scanner.sv
// Image is sampled only when a start is accepted and a finished map set waits until fc_ready
module window_scanner
    import cnn_pkg::*;
#(
    parameter int IN_SIZE      = 4,
    parameter int KERNEL_SIZE  = 3,
    localparam int OUT_SIZE    = IN_SIZE - KERNEL_SIZE + 1,
    localparam int PATCH_LEN   = KERNEL_SIZE * KERNEL_SIZE,
    localparam int MAP_LEN     = OUT_SIZE * OUT_SIZE,
    localparam int POS_W       = (MAP_LEN > 1) ? $clog2(MAP_LEN) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  sample_t          image [IN_SIZE][IN_SIZE],
    input  logic             fc_ready,
    output logic             ready,
    output sample_t          patch [PATCH_LEN],
    output logic             patch_valid,
    output logic [POS_W-1:0] patch_pos,
    output logic             maps_valid
);

    localparam int CNT_W = (OUT_SIZE > 1) ? $clog2(OUT_SIZE) : 1;

    scan_state_t      state;
    logic [CNT_W-1:0] row;  // Output row of the current window
    logic [CNT_W-1:0] col;  // Output column of the current window
    sample_t          image_q [IN_SIZE][IN_SIZE];
    logic             accept;
    logic             last_col;
    logic             last_row;

    assign ready       = (state == SCAN_IDLE);
    assign accept      = start && ready;
    assign patch_valid = (state == SCAN_RUN);
    assign maps_valid  = (state == SCAN_HOLD) && fc_ready;  // Hand-off to FC stage

    assign last_col  = (col == CNT_W'(OUT_SIZE - 1));
    assign last_row  = (row == CNT_W'(OUT_SIZE - 1));
    assign patch_pos = POS_W'(row * OUT_SIZE + col);  // Row-major map index

    // ----------------------------------------
    // Image capture
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            image_q <= image;
        end
    end

    // ----------------------------------------
    // Position counters and FSM
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SCAN_IDLE;
            row   <= '0;
            col   <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (accept) begin
                        row   <= '0;
                        col   <= '0;
                        state <= SCAN_RUN;
                    end
                end
                SCAN_RUN: begin
                    if (last_col) begin
                        col <= '0;
                        if (last_row) begin
                            row   <= '0;
                            state <= SCAN_HOLD;  // All positions written
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                SCAN_HOLD: begin
                    if (fc_ready) begin
                        state <= SCAN_IDLE;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Window select
    // ----------------------------------------
    always_comb begin
        for (int m = 0; m < KERNEL_SIZE; m++) begin
            for (int n = 0; n < KERNEL_SIZE; n++) begin
                patch[m * KERNEL_SIZE + n] = image_q[int'(row) + m][int'(col) + n];
            end
        end
    end

endmodule

//--- verification/cnn_infer_properties.sv
// Control timing checks on the top level that stay off while rst is high
module cnn_infer_properties #(
    parameter int MAP_LEN = 4
) (
    input logic clk,
    input logic rst,
    input logic start,
    input logic ready,
    input logic done,
    input logic patch_valid,
    input logic maps_valid
);

    int fail_count = 0;  // Assertion failures so far

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    no_overlap: assert property (@(posedge clk) disable iff (rst) !(maps_valid && patch_valid))
        else begin
            fail_count++;
            $error("maps_valid while patch_valid was high");
        end

    // One window per output position after each accepted start
    scan_length: assert property (@(posedge clk) disable iff (rst)
        (start && ready) |=> patch_valid [*MAP_LEN] ##1 !patch_valid)
        else begin
            fail_count++;
            $error("patch_valid run length differs from the map size");
        end

    busy_scan: assert property (@(posedge clk) disable iff (rst) patch_valid |-> !ready)
        else begin
            fail_count++;
            $error("ready high during a scan");
        end

endmodule

bind cnn_infer_top cnn_infer_properties #(
    .MAP_LEN (MAP_LEN)
) i_props (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .ready       (ready),
    .done        (done),
    .patch_valid (patch_valid),
    .maps_valid  (maps_valid)
);

//--- verification/cnn_ref_model.svh
// Model of the inference path for shared weights and zero biases that needs IN_SIZE and friends in scope
`ifndef CNN_REF_MODEL_SVH
`define CNN_REF_MODEL_SVH

// ----------------------------------------
// Network constants of the model
// ----------------------------------------
localparam int                 M_FRAC   = 8;
localparam logic signed [15:0] M_CONV_W = 16'sd16;  // 0.0625
localparam logic signed [15:0] M_FC1_W  = 16'sd8;
localparam logic signed [15:0] M_FC2_W  = 16'sd16;
localparam logic signed [15:0] M_FC1_B  = 16'sd0;
localparam logic signed [15:0] M_FC2_B  = 16'sd0;
localparam int                 M_OUT    = IN_SIZE - KERNEL_SIZE + 1;
localparam int                 M_FLAT   = NUM_FILTERS * M_OUT * M_OUT;

// Arithmetic shift by the fraction bits, then keep the low 16 bits
function automatic logic signed [15:0] rescale_q88(input logic signed [31:0] sum);
    logic signed [31:0] shifted;
    shifted = sum >>> M_FRAC;
    return shifted[15:0];
endfunction

// One conv output after ReLU
function automatic logic signed [15:0] conv_relu_point(input sample_t img [IN_SIZE][IN_SIZE],
                                                       input int r, input int c);
    logic signed [31:0] sum;
    logic signed [31:0] prod;
    logic signed [15:0] v;
    sum = 0;
    for (int m = 0; m < KERNEL_SIZE; m++) begin
        for (int n = 0; n < KERNEL_SIZE; n++) begin
            prod = img[r + m][c + n] * M_CONV_W;  // 16x16 into 32
            sum  = sum + prod;
        end
    end
    v = rescale_q88(sum);
    return (v < 0) ? 16'sd0 : v;
endfunction

// Full network, filter-major flattening
function automatic logic signed [15:0] model_infer(input sample_t img [IN_SIZE][IN_SIZE]);
    logic signed [15:0] flat_m [M_FLAT];
    logic signed [15:0] hid [FC1_NEURONS];
    logic signed [31:0] sum;
    logic signed [31:0] prod;
    for (int f = 0; f < NUM_FILTERS; f++) begin
        for (int k = 0; k < M_OUT * M_OUT; k++) begin
            flat_m[f * M_OUT * M_OUT + k] = conv_relu_point(img, k / M_OUT, k % M_OUT);
        end
    end
    for (int h = 0; h < FC1_NEURONS; h++) begin
        sum = 0;
        for (int i = 0; i < M_FLAT; i++) begin
            prod = flat_m[i] * M_FC1_W;
            sum  = sum + prod;
        end
        hid[h] = rescale_q88(sum) + M_FC1_B;  // Wraps at 16 bits
    end
    sum = 0;
    for (int j = 0; j < FC1_NEURONS; j++) begin
        prod = hid[j] * M_FC2_W;
        sum  = sum + prod;
    end
    return rescale_q88(sum) + M_FC2_B;
endfunction

`endif

//--- verification/cnn_infer_tb.sv
// Inputs change on the falling edge, outputs are sampled there too, and results are expected in order
module cnn_infer_tb
    import cnn_pkg::*;
();

    localparam int          IN_SIZE     = 4;
    localparam int          KERNEL_SIZE = 3;
    localparam int          NUM_FILTERS = 4;
    localparam int          FC1_NEURONS = 8;
    localparam logic [15:0] SEED        = 16'd39770;
    localparam int          STREAM_LEN  = 30;
    localparam int          WAIT_LIMIT  = 200;  // Cycles per wait

    logic    clk;
    logic    rst;
    logic    start;
    sample_t image [IN_SIZE][IN_SIZE];
    logic    ready;
    sample_t result;
    logic    done;

    logic [15:0] lfsr_state = SEED;
    sample_t     expected_q [$];
    int          cycle = 0;
    int          accept_cycle = 0;
    int          done_cycle = 0;
    int          accept_count = 0;
    int          done_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;
    int          ready_low_run = 0;
    int          max_ready_low = 0;

    `include "cnn_ref_model.svh"

    tb_clock_gen #(.PERIOD(4)) i_clk (.clk(clk));

    cnn_infer_top #(
        .IN_SIZE     (IN_SIZE),
        .KERNEL_SIZE (KERNEL_SIZE),
        .NUM_FILTERS (NUM_FILTERS),
        .FC1_NEURONS (FC1_NEURONS)
    ) i_dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .image  (image),
        .ready  (ready),
        .result (result),
        .done   (done)
    );

    // ----------------------------------------
    // Random bits
    // ----------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];  // x^16 + x^14 + x^13 + x^11 + 1
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // ----------------------------------------
    // Checks and reporting
    // ----------------------------------------
    task automatic check_value(input string name, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("Check failed at %0t: %s", $time, what);
            error_count++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: passed", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed", test_count, name);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic fill_image(input logic all_negative);
        logic [31:0] bits;
        for (int r = 0; r < IN_SIZE; r++) begin
            for (int c = 0; c < IN_SIZE; c++) begin
                if (all_negative) begin
                    bits = take_bits(14);
                    image[r][c] = {2'b11, bits[13:0]};  // -16384 to -1
                end else begin
                    bits = take_bits(16);
                    image[r][c] = bits[15:0];
                end
            end
        end
    endtask

    // Start stays high until the scanner takes it
    task automatic send_image(input logic all_negative);
        int waited;
        waited = 0;
        @(negedge clk);
        fill_image(all_negative);
        start = 1'b1;
        while (!ready) begin
            if (waited == WAIT_LIMIT) give_up("ready never returned high for a start");
            waited++;
            @(negedge clk);
        end
        expected_q.push_back(model_infer(image));
        accept_count++;
        accept_cycle = cycle;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            if (waited == WAIT_LIMIT) give_up("an accepted image never produced done");
            waited++;
            @(negedge clk);
        end
    endtask

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------
    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin
        if (!rst) begin
            ready_low_run = ready ? 0 : ready_low_run + 1;
            if (ready_low_run > max_ready_low) max_ready_low = ready_low_run;
            if (done) begin
                done_count++;
                done_cycle = cycle;
                if (expected_q.size() == 0) begin
                    check_true(1'b0, "done pulsed with no accepted start pending");
                end else begin
                    check_value("result", result, expected_q.pop_front());
                end
            end
        end
    end

    initial begin
        int errs;
        int ignored;
        int total_errors;
        rst   = 1'b1;
        start = 1'b0;
        for (int r = 0; r < IN_SIZE; r++) begin
            for (int c = 0; c < IN_SIZE; c++) begin
                image[r][c] = '0;
            end
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        errs = error_count;
        @(negedge clk);
        check_value("ready", ready, 1);
        check_value("done", done, 0);
        check_value("result", result, 0);
        end_test("reset state", errs);

        errs = error_count;
        send_image(1'b0);
        wait_drain();
        check_value("done latency", done_cycle - accept_cycle, 15);  // FC stage idle
        end_test("single image", errs);

        errs = error_count;
        send_image(1'b1);
        wait_drain();
        check_value("result", result, 0);
        end_test("negative image", errs);

        errs = error_count;
        max_ready_low = 0;
        for (int k = 0; k < STREAM_LEN; k++) begin
            repeat (take_bits(2)) @(negedge clk);
            send_image(1'b0);
        end
        wait_drain();
        check_true(max_ready_low > 5, "no back-pressure seen during the stream");
        end_test("random stream", errs);

        // Second image waits in the scanner so ready stays low for a while
        errs    = error_count;
        ignored = 0;
        send_image(1'b0);
        send_image(1'b0);
        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            start = !ready && (take_bits(1) != 0);
            if (start) ignored++;
        end
        @(negedge clk);
        start = 1'b0;
        wait_drain();
        repeat (20) @(negedge clk);
        check_true(ignored > 0, "no start pulse was given while ready was low");
        check_value("done count", done_count, accept_count);
        end_test("ignored starts", errs);

        total_errors = error_count + i_dut.i_props.fail_count;
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 test_count, failed_tests, check_count, error_count, i_dut.i_props.fail_count);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
// Free-running clock that starts low and needs an even PERIOD
module tb_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule
